// File: include/fetch_group_params.svh
// Width, slot-count, NOP and reset-PC macros for the fetch-group mux; include before use
`ifndef FETCH_GROUP_PARAMS_SVH
`define FETCH_GROUP_PARAMS_SVH

// ============================================================
// Datapath widths
// ============================================================
`define FG_LINE_W 512
`define FG_INS_W 64
`define FG_PC_W 32
`define FG_IRQ_W 3
`define FG_OPC_W 7

// Number of instruction slots handed to decode per fetch group
`define FG_SLOTS 4

// The NOP opcode lives in the low opcode field of the instruction word
`define FG_OP_NOP 7'h0B
`define FG_NOP_WORD {{(`FG_INS_W-`FG_OPC_W){1'b0}}, `FG_OP_NOP}

// Reset vector, also reported as the branch target when nothing matches
`define FG_RST_PC 32'hFFFC0000

`endif

// File: src/fetch_group_pkg.sv
// Shared opcode, slot and group types for the fetch-group mux; import where the types are used
`include "fetch_group_params.svh"

package fetch_group_pkg;

	// ============================================================
	// Opcodes
	// ============================================================

	// Only the opcodes this stage has to recognise are listed
	// OP_ALU stands in for every ordinary instruction
	typedef enum logic [`FG_OPC_W-1:0]
	{
		OP_ALU = 7'h04,
		OP_NOP = `FG_OP_NOP,
		OP_BSR = 7'h20,
		OP_JSR = 7'h21
	} opcode_e;

	// ============================================================
	// Slot and group
	// ============================================================

	// One issue slot as seen by decode
	// The opcode sits in ins[6:0] and the displacement in ins[63:10]
	typedef struct packed
	{
		// Raw instruction word
		logic [`FG_INS_W-1:0] ins;
		// Address of this instruction
		logic [`FG_PC_W-1:0] pc;
		// Slot may be issued
		logic v;
		// Slot was taken over by an NMI or hardware interrupt
		logic hwi;
		// Interrupt level carried along with the slot
		logic [`FG_IRQ_W-1:0] hwi_level;
		// Slot lies on the wrong side of a branch miss
		logic squash;
	} fetch_slot_t;

	// Slot 0 is the oldest instruction of the group
	typedef fetch_slot_t [`FG_SLOTS-1:0] fetch_group_t;

endpackage

// File: src/fetch_group_if.sv
// Aligned instruction group passed from the line aligner to the issue register, no handshake
`timescale 1ns/1ns
`include "fetch_group_params.svh"

interface fetch_group_if;

	// Instruction words after alignment, word 0 is at the fetch PC
	logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] ins;

	// Address of each word in the group
	logic [`FG_SLOTS-1:0][`FG_PC_W-1:0] pc;

	// Fetch unit repeated the previous group
	logic redundant;

	// The aligner produces the group every cycle
	modport aligner
	(
		output ins,
		output pc,
		output redundant
	);

	// The issue register samples it whenever its enable is high
	modport issue
	(
		input ins,
		input pc,
		input redundant
	);

endinterface

// File: src/line_aligner.sv
// Aligns the cache line to the fetch PC, slices the slots and flags a repeated group
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module line_aligner
(
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 advance_i,
	input  logic [`FG_LINE_W-1:0] line_i,
	input  logic [`FG_PC_W-1:0]   pc_i,
	fetch_group_if.aligner       grp
);

	// ============================================================
	// Geometry
	// ============================================================

	// Words in one cache line
	localparam int LINE_WORDS = `FG_LINE_W / `FG_INS_W;
	// Bits needed to pick a word inside the line
	localparam int WSEL_W = $clog2(LINE_WORDS);
	// Lowest PC bit that selects a word rather than a byte
	localparam int BYTE_LSB = $clog2(`FG_INS_W / 8);
	// A word index times this many bits is a bit offset
	localparam int BIT_SH = $clog2(`FG_INS_W);
	// Bits that make up one fetch group
	localparam int GROUP_W = `FG_SLOTS * `FG_INS_W;
	// Line plus enough NOP padding to fill a group from the last word
	localparam int PAD_W = `FG_LINE_W + GROUP_W;

	// Line with NOP words stacked on top of it
	logic [PAD_W-1:0] padded;
	// Word index of the fetch PC inside the line
	logic [WSEL_W-1:0] word_sel;
	// Bit offset for the shift
	logic [WSEL_W+BIT_SH-1:0] shamt;
	// Padded line after the shift
	logic [PAD_W-1:0] shifted;
	// The group as it lands in the slots
	logic [GROUP_W-1:0] aligned;

	// History of the last group the fetch unit advanced past
	logic [`FG_PC_W-1:0] prev_pc;
	logic [GROUP_W-1:0] prev_aligned;

	// ============================================================
	// Alignment
	// ============================================================

	// Slots past the end of the line pick up NOPs from the padding
	assign padded = {{`FG_SLOTS{`FG_NOP_WORD}}, line_i};

	// PC bits 5..3 pick the starting word
	assign word_sel = pc_i[BYTE_LSB+WSEL_W-1:BYTE_LSB];
	assign shamt = {word_sel, {BIT_SH{1'b0}}};
	assign shifted = padded >> shamt;
	assign aligned = shifted[GROUP_W-1:0];

	// Hand each word and its address to the interface
	always_comb
	begin
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			grp.ins[i] = aligned[i*`FG_INS_W +: `FG_INS_W];
			// Each slot is one word further along
			grp.pc[i] = pc_i + `FG_PC_W'(i * (`FG_INS_W / 8));
		end
	end

	// ============================================================
	// Redundant group detection
	// ============================================================

	// History moves only when the fetch unit says it has advanced
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			prev_pc <= '0;
			prev_aligned <= '0;
		end
		else if (advance_i)
		begin
			prev_pc <= pc_i;
			prev_aligned <= aligned;
		end
	end

	// Same address and same words means this group was already issued
	// The issue register swaps the words for NOPs when this is set
	assign grp.redundant = (prev_pc == pc_i) && (prev_aligned == aligned);

endmodule

// File: src/slot_issue_reg.sv
// Marks interrupts and branch-miss squashes on each slot and registers the group on the enable
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module slot_issue_reg
(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        en_i,
	fetch_group_if.issue                grp,
	input  logic                        nmi_i,
	input  logic                        irqf_i,
	input  logic [`FG_IRQ_W-1:0]        irq_level_i,
	input  logic                        branchmiss_i,
	input  logic [`FG_PC_W-1:0]         miss_pc_i,
	output fetch_group_pkg::fetch_group_t group_o
);

	import fetch_group_pkg::*;

	// Group as it will be captured on the next enabled edge
	fetch_group_t nxt_group;
	// Contents of every slot right after reset
	fetch_slot_t rst_slot;
	// Any interrupt takes over the whole group
	logic take_irq;

	assign take_irq = nmi_i | irqf_i;

	// ============================================================
	// Slot marking
	// ============================================================

	always_comb
	begin
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			// A repeated group issues NOPs so nothing runs twice
			if (grp.redundant)
				nxt_group[i].ins = `FG_NOP_WORD;
			else
				nxt_group[i].ins = grp.ins[i];
			nxt_group[i].pc = grp.pc[i];

			// The interrupt level rides along in every slot, used or not
			nxt_group[i].hwi_level = irq_level_i;
			nxt_group[i].hwi = take_irq;

			// Slots older than the miss target belong to the wrong path
			nxt_group[i].squash = branchmiss_i && (miss_pc_i > grp.pc[i]);

			// Interrupted or squashed slots keep their word but do not issue
			nxt_group[i].v = !take_irq && !nxt_group[i].squash;
		end
	end

	// Reset leaves a harmless NOP at the reset vector in each slot
	always_comb
	begin
		rst_slot = '0;
		rst_slot.ins = `FG_NOP_WORD;
		rst_slot.pc = `FG_RST_PC;
	end

	// ============================================================
	// Issue register
	// ============================================================

	// With en_i low the group simply holds, which is the only stall
	always_ff @(posedge clk)
	begin
		if (rst_i)
			group_o <= {`FG_SLOTS{rst_slot}};
		else if (en_i)
			group_o <= nxt_group;
	end

endmodule

// File: src/branch_target_detect.sv
// Scans the registered group for the first BSR or JSR and forms the branch request and target
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module branch_target_detect
(
	input  fetch_group_pkg::fetch_group_t group_i,
	input  logic                          stomp_i,
	output logic                          do_bsr_o,
	output logic [`FG_PC_W-1:0]           bsr_tgt_o
);

	import fetch_group_pkg::*;

	// The displacement field starts at this instruction bit
	localparam int DISP_LSB = 10;

	// Per-slot decode of the two call opcodes
	logic [`FG_SLOTS-1:0] is_bsr;
	logic [`FG_SLOTS-1:0] is_jsr;
	// Target each slot would produce if it were the first match
	logic [`FG_SLOTS-1:0][`FG_PC_W-1:0] slot_tgt;

	// ============================================================
	// Per-slot decode
	// ============================================================

	// Opcodes are checked whether or not the slot is valid
	always_comb
	begin
		opcode_e opc;
		logic [`FG_INS_W-1:0] disp;
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			opc = opcode_e'(group_i[i].ins[`FG_OPC_W-1:0]);
			is_bsr[i] = (opc == OP_BSR);
			is_jsr[i] = (opc == OP_JSR);

			// Sign-extend bits 63..10, the target wraps at the PC width
			disp = {{DISP_LSB{group_i[i].ins[`FG_INS_W-1]}},
				group_i[i].ins[`FG_INS_W-1:DISP_LSB]};

			// JSR jumps to the absolute value, BSR is relative to its own PC
			if (is_jsr[i])
				slot_tgt[i] = disp[`FG_PC_W-1:0];
			else
				slot_tgt[i] = group_i[i].pc + disp[`FG_PC_W-1:0];
		end
	end

	// ============================================================
	// First-match select
	// ============================================================

	// Walking down from the top lets the lowest matching slot win
	always_comb
	begin
		bsr_tgt_o = `FG_RST_PC;
		for (int i = `FG_SLOTS - 1; i >= 0; i--)
		begin
			if (is_bsr[i] || is_jsr[i])
				bsr_tgt_o = slot_tgt[i];
		end
	end

	// A stomped group must not redirect fetch
	assign do_bsr_o = (|(is_bsr | is_jsr)) & ~stomp_i;

endmodule

// File: src/fetch_group_top.sv
// Top level of the fetch-group mux, connects aligner, issue register and branch detect
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module fetch_group_top
(
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          en_i,
	input  logic                          advance_i,
	input  logic [`FG_LINE_W-1:0]         line_i,
	input  logic [`FG_PC_W-1:0]           pc_i,
	input  logic                          nmi_i,
	input  logic                          irqf_i,
	input  logic [`FG_IRQ_W-1:0]          irq_level_i,
	input  logic                          branchmiss_i,
	input  logic [`FG_PC_W-1:0]           miss_pc_i,
	input  logic                          stomp_i,
	output fetch_group_pkg::fetch_group_t group_o,
	output logic                          do_bsr_o,
	output logic [`FG_PC_W-1:0]           bsr_tgt_o
);

	// Aligned words, PCs and the repeat flag, combinational from the inputs
	fetch_group_if grp_if ();

	// ============================================================
	// Fetch side, same cycle as line_i and pc_i
	// ============================================================

	line_aligner u_aligner
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.advance_i (advance_i),
		.line_i    (line_i),
		.pc_i      (pc_i),
		.grp       (grp_if.aligner)
	);

	// ============================================================
	// Issue register, one enabled cycle of latency
	// ============================================================

	slot_issue_reg u_issue
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.grp          (grp_if.issue),
		.nmi_i        (nmi_i),
		.irqf_i       (irqf_i),
		.irq_level_i  (irq_level_i),
		.branchmiss_i (branchmiss_i),
		.miss_pc_i    (miss_pc_i),
		.group_o      (group_o)
	);

	// Branch request follows group_o in the same cycle
	branch_target_detect u_branch
	(
		.group_i   (group_o),
		.stomp_i   (stomp_i),
		.do_bsr_o  (do_bsr_o),
		.bsr_tgt_o (bsr_tgt_o)
	);

endmodule

// File: tests/tb_fetch_group_assertions.sv
// Concurrent checks on the fetch-group top level, attached to every instance by the bind below
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module tb_fetch_group_assertions
(
	input logic                          clk,
	input logic                          rst_i,
	input logic                          en_i,
	input fetch_group_pkg::fetch_group_t group_o,
	input logic                          do_bsr_o
);

	import fetch_group_pkg::*;

	// Per-slot flags gathered into vectors
	logic [`FG_SLOTS-1:0] slot_v;
	logic [`FG_SLOTS-1:0] slot_hwi;

	// Number of assertion failures so far
	int fail_count = 0;

	always_comb
	begin
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			slot_v[i] = group_o[i].v;
			slot_hwi[i] = group_o[i].hwi;
		end
	end

	// ============================================================
	// Properties
	// ============================================================

	// The reset group is all NOPs, so nothing is valid and fetch is not redirected
	a_reset_quiet: assert property (@(posedge clk) rst_i |=> (slot_v == '0) && !do_bsr_o)
		else
		begin
			fail_count++;
			$error("valid slot or branch request in the group right after reset");
		end

	// An interrupted slot is never issued
	a_hwi_not_valid: assert property (@(posedge clk) disable iff (rst_i) (slot_v & slot_hwi) == '0)
		else
		begin
			fail_count++;
			$error("slot marked both interrupted and valid");
		end

	// With the enable low the issue register holds
	a_hold_on_stall: assert property (@(posedge clk) disable iff (rst_i) !en_i |=> $stable(group_o))
		else
		begin
			fail_count++;
			$error("group changed across a cycle with the enable low");
		end

endmodule

bind fetch_group_top tb_fetch_group_assertions u_assert
(
	.clk      (clk),
	.rst_i    (rst_i),
	.en_i     (en_i),
	.group_o  (group_o),
	.do_bsr_o (do_bsr_o)
);

// File: tests/tb_fetch_group.sv
// Self-checking testbench for the fetch-group mux, compiled with the sources listed in project.f
`timescale 1ns/1ns
`include "fetch_group_params.svh"

module tb_fetch_group;

	import fetch_group_pkg::*;

	// ============================================================
	// Run length
	// ============================================================

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 16;
	localparam int TEST_CYCLES = 24;
	localparam int NUM_TESTS = 6;
	// Every test also spends one drain cycle after its last stimulus
	localparam int TOTAL_CYCLES = RST_CYCLES + NUM_TESTS * (TEST_CYCLES + 1);

	logic clk;
	logic rst_i;
	logic en_i;
	logic advance_i;
	logic [`FG_LINE_W-1:0] line_i;
	logic [`FG_PC_W-1:0] pc_i;
	logic nmi_i;
	logic irqf_i;
	logic [`FG_IRQ_W-1:0] irq_level_i;
	logic branchmiss_i;
	logic [`FG_PC_W-1:0] miss_pc_i;
	logic stomp_i;
	fetch_group_t group_o;
	logic do_bsr_o;
	logic [`FG_PC_W-1:0] bsr_tgt_o;

	// Reference model state and bookkeeping
	fetch_group_t exp_group;
	logic [`FG_PC_W-1:0] hist_pc;
	logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] hist_words;
	logic [31:0] lcg_state = 32'h0da4d21f;
	int err_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	fetch_group_top dut
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.en_i         (en_i),
		.advance_i    (advance_i),
		.line_i       (line_i),
		.pc_i         (pc_i),
		.nmi_i        (nmi_i),
		.irqf_i       (irqf_i),
		.irq_level_i  (irq_level_i),
		.branchmiss_i (branchmiss_i),
		.miss_pc_i    (miss_pc_i),
		.stomp_i      (stomp_i),
		.group_o      (group_o),
		.do_bsr_o     (do_bsr_o),
		.bsr_tgt_o    (bsr_tgt_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// Random source and reference model
	// ============================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [`FG_LINE_W-1:0] random_line();
		logic [`FG_LINE_W-1:0] line;
		for (int k = 0; k < `FG_LINE_W / 32; k++)
			line[k*32 +: 32] = lcg_next();
		return line;
	endfunction

	// Slot i holds line word (PC word index + i), or a NOP once past word 7
	function automatic logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] ref_words();
		logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] words;
		int k;
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			k = int'(pc_i[5:3]) + i;
			words[i] = (k < 8) ? line_i[k*`FG_INS_W +: `FG_INS_W] : `FG_NOP_WORD;
		end
		return words;
	endfunction

	function automatic fetch_group_t ref_group(input logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] words);
		fetch_group_t g;
		logic repeat_grp;
		repeat_grp = (pc_i == hist_pc) && (words == hist_words);
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			g[i].ins = repeat_grp ? `FG_NOP_WORD : words[i];
			g[i].pc = pc_i + 32'(8 * i);
			g[i].hwi = nmi_i | irqf_i;
			g[i].hwi_level = irq_level_i;
			g[i].squash = branchmiss_i && (miss_pc_i > g[i].pc);
			g[i].v = !g[i].hwi && !g[i].squash;
		end
		return g;
	endfunction

	// Request bit on top of the target, the first BSR or JSR in slot order wins
	function automatic logic [`FG_PC_W:0] ref_branch(input fetch_group_t g, input logic stomp);
		logic [6:0] opc;
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			opc = g[i].ins[6:0];
			// Only the low 32 bits of the sign-extended displacement survive
			if (opc == OP_JSR)
				return {!stomp, g[i].ins[41:10]};
			if (opc == OP_BSR)
				return {!stomp, g[i].pc + g[i].ins[41:10]};
		end
		return {1'b0, `FG_RST_PC};
	endfunction

	// Model register and history follow the DUT at every edge
	always @(posedge clk)
	begin
		logic [`FG_SLOTS-1:0][`FG_INS_W-1:0] words;
		words = ref_words();
		if (rst_i)
		begin
			hist_pc = '0;
			hist_words = '0;
			for (int i = 0; i < `FG_SLOTS; i++)
			begin
				exp_group[i] = '0;
				exp_group[i].ins = `FG_NOP_WORD;
				exp_group[i].pc = `FG_RST_PC;
			end
		end
		else
		begin
			if (en_i)
				exp_group = ref_group(words);
			if (advance_i)
			begin
				hist_pc = pc_i;
				hist_words = words;
			end
		end
	end

	// ============================================================
	// Checking
	// ============================================================

	// Check errors plus failures of the bound assertions
	function automatic int error_total();
		return err_count + dut.u_assert.fail_count;
	endfunction

	task automatic check_group(input fetch_group_t got, input fetch_group_t exp);
		string msg;
		for (int i = 0; i < `FG_SLOTS; i++)
		begin
			if (got[i] !== exp[i])
			begin
				err_count++;
				msg = $sformatf("slot %0d ins %h/%h pc %h/%h", i, got[i].ins, exp[i].ins,
					got[i].pc, exp[i].pc);
				msg = {msg, $sformatf(" v %b/%b hwi %b/%b lvl %0d/%0d squash %b/%b",
					got[i].v, exp[i].v, got[i].hwi, exp[i].hwi, got[i].hwi_level,
					exp[i].hwi_level, got[i].squash, exp[i].squash)};
				$display("CHECK FAILED at %0t: %s (got/expected)", $time, msg);
			end
		end
	endtask

	task automatic check_branch(input logic got_do, input logic [`FG_PC_W-1:0] got_tgt,
		input logic exp_do, input logic [`FG_PC_W-1:0] exp_tgt);
		if (got_do !== exp_do || got_tgt !== exp_tgt)
		begin
			err_count++;
			$display("CHECK FAILED at %0t: branch request %b target %h, expected %b target %h",
				$time, got_do, got_tgt, exp_do, exp_tgt);
		end
	endtask

	// Outputs are sampled a quarter period after the edge, well before the next input change
	always @(posedge clk)
	begin
		logic [`FG_PC_W:0] exp_br;
		#(CLK_PERIOD / 4);
		exp_br = ref_branch(exp_group, stomp_i);
		check_group(group_o, exp_group);
		check_branch(do_bsr_o, bsr_tgt_o, exp_br[`FG_PC_W], exp_br[`FG_PC_W-1:0]);
	end

	// ============================================================
	// Stimulus
	// ============================================================

	// Kinds: 0 alignment, 1 repeat, 2 interrupt, 3 squash, 4 branch, 5 enable hold
	task automatic run_test(input string name, input int kind);
		logic [31:0] r;
		logic [31:0] s;
		logic [`FG_LINE_W-1:0] new_line;
		logic [`FG_PC_W-1:0] new_pc;
		logic [2:0] bsr_word;
		int errs_before;
		errs_before = error_total();
		for (int n = 0; n < TEST_CYCLES; n++)
		begin
			@(negedge clk);
			r = lcg_next();
			s = lcg_next();
			new_line = random_line();
			// Word index walks through all eight positions, padding included
			new_pc = {r[31:6], n[2:0], 3'b000};
			en_i = 1'b1;
			advance_i = 1'b1;
			nmi_i = 1'b0;
			irqf_i = 1'b0;
			irq_level_i = '0;
			branchmiss_i = 1'b0;
			miss_pc_i = '0;
			stomp_i = 1'b0;
			// A repeat cycle keeps both, the next one changes only the line or only the PC
			if (kind != 1 || n % 3 == 0)
			begin
				line_i = new_line;
				pc_i = new_pc;
			end
			else if (n % 6 == 2)
				line_i = new_line;
			else if (n % 6 == 5)
				pc_i = new_pc;
			case (kind)
				2:
				begin
					irqf_i = s[0];
					nmi_i = !s[0] || s[1];
					irq_level_i = s[4:2];
				end
				3:
				begin
					branchmiss_i = 1'b1;
					miss_pc_i = pc_i + 32'(s[5:0]) - 32'd16;
				end
				4:
				begin
					// The BSR lands at or just after the fetch word, so most groups hold it
					bsr_word = pc_i[5:3] + s[1:0];
					line_i[bsr_word*`FG_INS_W +: `FG_INS_W] = {lcg_next(), s[31:7], OP_BSR};
					if (s[3])
						line_i[s[6:4]*`FG_INS_W +: `FG_INS_W] = {lcg_next(), s[31:7], OP_JSR};
					stomp_i = (n % 4 == 3);
				end
				5:
				begin
					en_i = (n % 4 == 0);
					irqf_i = s[0];
					branchmiss_i = s[1];
					miss_pc_i = s;
				end
				default:
				begin
				end
			endcase
		end
		@(negedge clk);
		if (error_total() == errs_before)
		begin
			tests_passed++;
			$display("Test %s passed", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, error_total() - errs_before);
		end
	endtask

	initial
	begin
		rst_i = 1'b1;
		en_i = 1'b0;
		advance_i = 1'b0;
		line_i = '0;
		pc_i = '0;
		nmi_i = 1'b0;
		irqf_i = 1'b0;
		irq_level_i = '0;
		branchmiss_i = 1'b0;
		miss_pc_i = '0;
		stomp_i = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);
		rst_i = 1'b0;
		run_test("alignment", 0);
		run_test("redundant_group", 1);
		run_test("interrupt_marking", 2);
		run_test("branch_miss_squash", 3);
		run_test("bsr_jsr_detect", 4);
		run_test("enable_hold", 5);
		$display("Tests passed %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_passed, tests_failed, err_count, dut.u_assert.fail_count);
		if (error_total() == 0 && tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog with some margin over the planned run length
	initial
	begin
		#((TOTAL_CYCLES + 20) * CLK_PERIOD);
		$display("Watchdog: the simulation timed out before all tests finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
src/fetch_group_pkg.sv
src/fetch_group_if.sv
src/line_aligner.sv
src/slot_issue_reg.sv
src/branch_target_detect.sv
src/fetch_group_top.sv
tests/tb_fetch_group_assertions.sv
tests/tb_fetch_group.sv

// File: Bender.yml
package:
  name: fetch_group_mux

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/fetch_group_pkg.sv
      - src/fetch_group_if.sv
      - src/line_aligner.sv
      - src/slot_issue_reg.sv
      - src/branch_target_detect.sv
      - src/fetch_group_top.sv
      - target: test
        include_dirs:
          - include
        files:
          - tests/tb_fetch_group_assertions.sv
          - tests/tb_fetch_group.sv
